// File: design/soc_pkg.sv
`default_nettype none

package soc_pkg;

  // bus and line geometry
  localparam int ADDR_W     = 32;
  localparam int DATA_W     = 64;
  localparam int LINE_W     = 512;
  localparam int BEATS      = LINE_W / DATA_W;
  localparam int BEAT_IDX_W = 3;  // log2 of BEATS
  localparam int ID_W       = 4;

  // fixed burst attributes
  localparam logic [ID_W-1:0] AXI_ID         = '0;
  localparam logic [2:0]      AXI_SIZE_8B    = 3'd3;
  localparam logic [1:0]      AXI_BURST_INCR = 2'd1;

  // AXI response codes
  localparam logic [1:0] RESP_OKAY   = 2'd0;
  localparam logic [1:0] RESP_SLVERR = 2'd2;

  // core side op encoding
  localparam logic OP_READ  = 1'b0;
  localparam logic OP_WRITE = 1'b1;

endpackage

`default_nettype wire

// File: design/axi_rw_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module axi_rw_ctrl (
  input  wire                        clock,
  input  wire                        rst_n_i,
  // core side
  input  wire                        user_valid_i,
  input  wire                        user_req_i,
  input  wire [soc_pkg::ADDR_W-1:0]  user_addr_i,
  input  wire [7:0]                  user_blks_i,
  output logic                       user_ready_o,
  output logic [1:0]                 user_resp_o,
  input  wire [1:0]                  rd_resp_i,
  // write channels
  input  wire                        aw_ready_i,
  output logic                       aw_valid_o,
  input  wire                        w_ready_i,
  output logic                       w_valid_o,
  input  wire                        w_last_i,
  output logic                       w_fire_o,
  input  wire                        b_valid_i,
  input  wire [1:0]                  b_resp_i,
  output logic                       b_ready_o,
  // read channels
  input  wire                        ar_ready_i,
  output logic                       ar_valid_o,
  input  wire                        r_valid_i,
  input  wire                        r_last_i,
  output logic                       r_ready_o,
  output logic                       r_fire_o,
  // datapath control
  output logic                       load_o,
  output logic                       clear_o,
  output logic [soc_pkg::ADDR_W-1:0] axi_addr_o,
  output logic [7:0]                 axi_len_o
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_WRITE,  // AW and W in flight together
    S_WRESP,
    S_RADDR,
    S_RDATA,
    S_DONE
  } state_t;

  state_t     state_q;
  logic       aw_done_q;
  logic       w_done_q;
  logic       is_wr_q;
  logic [1:0] b_resp_q;
  logic       accept;
  logic       aw_fire;
  logic       aw_ok;
  logic       w_ok;

  assign accept  = (state_q == S_IDLE) && user_valid_i;
  assign load_o  = accept;
  assign clear_o = accept;

  assign aw_valid_o = (state_q == S_WRITE) && !aw_done_q;
  assign w_valid_o  = (state_q == S_WRITE) && !w_done_q;
  assign aw_fire    = aw_valid_o && aw_ready_i;
  assign w_fire_o   = w_valid_o && w_ready_i;

  // each phase counts as finished once its handshake is seen, now or earlier
  assign aw_ok = aw_done_q || aw_fire;
  assign w_ok  = w_done_q || (w_fire_o && w_last_i);

  assign b_ready_o  = (state_q == S_WRESP);
  assign ar_valid_o = (state_q == S_RADDR);
  assign r_ready_o  = (state_q == S_RDATA);
  assign r_fire_o   = r_valid_i && r_ready_o;

  assign user_ready_o = (state_q == S_DONE);
  assign user_resp_o  = is_wr_q ? b_resp_q : rd_resp_i;  // both sides already registered

  always_ff @(posedge clock) begin
    if (!rst_n_i) begin
      state_q   <= S_IDLE;
      aw_done_q <= 1'b0;
      w_done_q  <= 1'b0;
      is_wr_q   <= 1'b0;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (user_valid_i) begin
            aw_done_q <= 1'b0;
            w_done_q  <= 1'b0;
            case (user_req_i)
              soc_pkg::OP_WRITE: begin
                is_wr_q <= 1'b1;
                state_q <= S_WRITE;
              end
              soc_pkg::OP_READ: begin
                is_wr_q <= 1'b0;
                state_q <= S_RADDR;
              end
              default: state_q <= S_IDLE;
            endcase
          end
        end
        S_WRITE: begin
          if (aw_fire) aw_done_q <= 1'b1;
          if (w_fire_o && w_last_i) w_done_q <= 1'b1;
          if (aw_ok && w_ok) state_q <= S_WRESP;
        end
        S_WRESP: if (b_valid_i) state_q <= S_DONE;
        S_RADDR: if (ar_ready_i) state_q <= S_RDATA;
        S_RDATA: if (r_fire_o && r_last_i) state_q <= S_DONE;
        S_DONE:  state_q <= S_IDLE;  // ready pulse lasts one cycle
        default: state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      axi_addr_o <= user_addr_i;
      axi_len_o  <= user_blks_i;
    end
    if (b_ready_o && b_valid_i) b_resp_q <= b_resp_i;
  end

endmodule

`default_nettype wire

// File: design/wdata_serializer.sv
`timescale 1ns/1ps
`default_nettype none

module wdata_serializer (
  input  wire                        clock,
  input  wire                        rst_n_i,
  input  wire                        load_i,
  input  wire [soc_pkg::LINE_W-1:0]  line_i,
  input  wire [7:0]                  len_i,
  input  wire                        w_fire_i,
  output logic [soc_pkg::DATA_W-1:0] w_data_o,
  output logic [7:0]                 w_strb_o,
  output logic                       w_last_o
);

  logic [soc_pkg::LINE_W-1:0]     line_q;
  logic [7:0]                     len_q;
  logic [soc_pkg::BEAT_IDX_W-1:0] cnt_q;

  // current beat always sits in the low word
  assign w_data_o = line_q[soc_pkg::DATA_W-1:0];
  assign w_strb_o = {(soc_pkg::DATA_W/8){1'b1}};
  assign w_last_o = ({5'd0, cnt_q} == len_q);

  always_ff @(posedge clock) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
      len_q <= '0;
    end else if (load_i) begin
      cnt_q <= '0;
      len_q <= len_i;
    end else if (w_fire_i) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (load_i) begin
      line_q <= line_i;
    end else if (w_fire_i) begin
      line_q <= line_q >> soc_pkg::DATA_W;  // next beat down
    end
  end

endmodule

`default_nettype wire

// File: design/rdata_assembler.sv
`timescale 1ns/1ps
`default_nettype none

module rdata_assembler (
  input  wire                        clock,
  input  wire                        rst_n_i,
  input  wire                        clear_i,
  input  wire                        r_fire_i,
  input  wire [soc_pkg::DATA_W-1:0]  r_data_i,
  input  wire [1:0]                  r_resp_i,
  output logic [soc_pkg::LINE_W-1:0] line_o,
  output logic [1:0]                 resp_o
);

  logic [soc_pkg::BEATS-1:0][soc_pkg::DATA_W-1:0] line_q;
  logic [soc_pkg::BEAT_IDX_W-1:0]                 idx_q;
  logic [1:0]                                     resp_q;

  assign line_o = line_q;
  assign resp_o = resp_q;

  always_ff @(posedge clock) begin
    if (!rst_n_i) begin
      idx_q  <= '0;
      resp_q <= soc_pkg::RESP_OKAY;
    end else if (clear_i) begin
      idx_q  <= '0;
      resp_q <= soc_pkg::RESP_OKAY;
    end else if (r_fire_i) begin
      idx_q <= idx_q + 1'b1;
      // first error wins
      if (resp_q == soc_pkg::RESP_OKAY) resp_q <= r_resp_i;
    end
  end

  // slots past the burst length keep the zeros from clear
  always_ff @(posedge clock) begin
    if (clear_i) begin
      line_q <= '0;
    end else if (r_fire_i) begin
      line_q[idx_q] <= r_data_i;
    end
  end

endmodule

`default_nettype wire

// File: design/soc_top.sv
`timescale 1ns/1ps
`default_nettype none

module soc_top (
  input  wire                        clock,
  input  wire                        rst_n_i,
  // core side line port
  input  wire                        user_valid_i,
  input  wire                        user_req_i,
  input  wire [soc_pkg::ADDR_W-1:0]  user_addr_i,
  input  wire [7:0]                  user_blks_i,
  input  wire [soc_pkg::LINE_W-1:0]  user_wdata_i,
  output logic                       user_ready_o,
  output logic [1:0]                 user_resp_o,
  output logic [soc_pkg::LINE_W-1:0] user_rdata_o,
  // AXI4 master
  input  wire                        io_master_awready_i,
  output logic                       io_master_awvalid_o,
  output logic [soc_pkg::ADDR_W-1:0] io_master_awaddr_o,
  output logic [soc_pkg::ID_W-1:0]   io_master_awid_o,
  output logic [7:0]                 io_master_awlen_o,
  output logic [2:0]                 io_master_awsize_o,
  output logic [1:0]                 io_master_awburst_o,
  input  wire                        io_master_wready_i,
  output logic                       io_master_wvalid_o,
  output logic [soc_pkg::DATA_W-1:0] io_master_wdata_o,
  output logic [7:0]                 io_master_wstrb_o,
  output logic                       io_master_wlast_o,
  output logic                       io_master_bready_o,
  input  wire                        io_master_bvalid_i,
  input  wire [1:0]                  io_master_bresp_i,
  input  wire                        io_master_arready_i,
  output logic                       io_master_arvalid_o,
  output logic [soc_pkg::ADDR_W-1:0] io_master_araddr_o,
  output logic [soc_pkg::ID_W-1:0]   io_master_arid_o,
  output logic [7:0]                 io_master_arlen_o,
  output logic [2:0]                 io_master_arsize_o,
  output logic [1:0]                 io_master_arburst_o,
  output logic                       io_master_rready_o,
  input  wire                        io_master_rvalid_i,
  input  wire [1:0]                  io_master_rresp_i,
  input  wire [soc_pkg::DATA_W-1:0]  io_master_rdata_i,
  input  wire                        io_master_rlast_i
);

  logic [soc_pkg::ADDR_W-1:0] axi_addr;
  logic [7:0]                 axi_len;
  logic                       w_fire;
  logic                       w_last;
  logic                       r_fire;
  logic                       load;
  logic                       clear;
  logic [1:0]                 rd_resp;

  // one request at a time, so AW and AR share address and length
  assign io_master_awaddr_o  = axi_addr;
  assign io_master_araddr_o  = axi_addr;
  assign io_master_awlen_o   = axi_len;
  assign io_master_arlen_o   = axi_len;
  assign io_master_awid_o    = soc_pkg::AXI_ID;
  assign io_master_arid_o    = soc_pkg::AXI_ID;
  assign io_master_awsize_o  = soc_pkg::AXI_SIZE_8B;
  assign io_master_arsize_o  = soc_pkg::AXI_SIZE_8B;
  assign io_master_awburst_o = soc_pkg::AXI_BURST_INCR;
  assign io_master_arburst_o = soc_pkg::AXI_BURST_INCR;
  assign io_master_wlast_o   = w_last;

  axi_rw_ctrl u_ctrl (
    .clock        (clock),
    .rst_n_i      (rst_n_i),
    .user_valid_i (user_valid_i),
    .user_req_i   (user_req_i),
    .user_addr_i  (user_addr_i),
    .user_blks_i  (user_blks_i),
    .user_ready_o (user_ready_o),
    .user_resp_o  (user_resp_o),
    .rd_resp_i    (rd_resp),
    .aw_ready_i   (io_master_awready_i),
    .aw_valid_o   (io_master_awvalid_o),
    .w_ready_i    (io_master_wready_i),
    .w_valid_o    (io_master_wvalid_o),
    .w_last_i     (w_last),
    .w_fire_o     (w_fire),
    .b_valid_i    (io_master_bvalid_i),
    .b_resp_i     (io_master_bresp_i),
    .b_ready_o    (io_master_bready_o),
    .ar_ready_i   (io_master_arready_i),
    .ar_valid_o   (io_master_arvalid_o),
    .r_valid_i    (io_master_rvalid_i),
    .r_last_i     (io_master_rlast_i),
    .r_ready_o    (io_master_rready_o),
    .r_fire_o     (r_fire),
    .load_o       (load),
    .clear_o      (clear),
    .axi_addr_o   (axi_addr),
    .axi_len_o    (axi_len)
  );

  wdata_serializer u_wser (
    .clock    (clock),
    .rst_n_i  (rst_n_i),
    .load_i   (load),
    .line_i   (user_wdata_i),
    .len_i    (user_blks_i),
    .w_fire_i (w_fire),
    .w_data_o (io_master_wdata_o),
    .w_strb_o (io_master_wstrb_o),
    .w_last_o (w_last)
  );

  rdata_assembler u_rasm (
    .clock    (clock),
    .rst_n_i  (rst_n_i),
    .clear_i  (clear),
    .r_fire_i (r_fire),
    .r_data_i (io_master_rdata_i),
    .r_resp_i (io_master_rresp_i),
    .line_o   (user_rdata_o),
    .resp_o   (rd_resp)
  );

endmodule

`default_nettype wire

// File: test/axi_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module axi_mem_model (
  input  wire                        clock,
  input  wire                        rst_n_i,
  input  wire [4:0]                  rnd_i,  // one stall bit per channel
  input  wire                        awvalid_i,
  output logic                       awready_o,
  input  wire [soc_pkg::ADDR_W-1:0]  awaddr_i,
  input  wire [7:0]                  awlen_i,
  input  wire                        wvalid_i,
  output logic                       wready_o,
  input  wire [soc_pkg::DATA_W-1:0]  wdata_i,
  input  wire                        wlast_i,
  output logic                       bvalid_o,
  input  wire                        bready_i,
  output logic [1:0]                 bresp_o,
  input  wire                        arvalid_i,
  output logic                       arready_o,
  input  wire [soc_pkg::ADDR_W-1:0]  araddr_i,
  input  wire [7:0]                  arlen_i,
  output logic                       rvalid_o,
  input  wire                        rready_i,
  output logic [soc_pkg::DATA_W-1:0] rdata_o,
  output logic [1:0]                 rresp_o,
  output logic                       rlast_o
);

  logic [soc_pkg::DATA_W-1:0] mem [256];
  logic [soc_pkg::DATA_W-1:0] wbuf [8];  // W beats may arrive before AW
  logic [soc_pkg::ADDR_W-1:0] waddr_q;
  logic [soc_pkg::ADDR_W-1:0] raddr_q;
  logic [7:0]                 wlen_q;
  logic [7:0]                 rlen_q;
  logic [7:0]                 rcnt_q;
  logic [2:0]                 wcnt_q;
  logic                       aw_got_q;
  logic                       w_got_q;
  logic                       ar_got_q;

  assign awready_o = !aw_got_q && rnd_i[0];
  assign wready_o  = !w_got_q && rnd_i[1];
  assign arready_o = !ar_got_q && rnd_i[2];

  initial begin
    for (int i = 0; i < 256; i++) mem[i] = {32'h1000_0000 + 32'(i), 32'hffff_ffff - 32'(i)};
  end

  always @(posedge clock) begin
    if (!rst_n_i) begin
      aw_got_q <= 1'b0;
      w_got_q  <= 1'b0;
      ar_got_q <= 1'b0;
      wcnt_q   <= '0;
      bvalid_o <= 1'b0;
      rvalid_o <= 1'b0;
      rlast_o  <= 1'b0;
    end else begin
      if (awvalid_i && awready_o) begin
        aw_got_q <= 1'b1;
        waddr_q  <= awaddr_i;
        wlen_q   <= awlen_i;
      end
      if (wvalid_i && wready_o) begin
        wbuf[wcnt_q] <= wdata_i;
        wcnt_q       <= wcnt_q + 3'd1;
        if (wlast_i) w_got_q <= 1'b1;
      end
      if (aw_got_q && w_got_q && !bvalid_o && rnd_i[3]) begin
        bvalid_o <= 1'b1;
        bresp_o  <= waddr_q[31] ? soc_pkg::RESP_SLVERR : soc_pkg::RESP_OKAY;
      end
      if (bvalid_o && bready_i) begin
        bvalid_o <= 1'b0;
        aw_got_q <= 1'b0;
        w_got_q  <= 1'b0;
        wcnt_q   <= '0;
        // error region drops the write
        if (!waddr_q[31]) begin
          for (int i = 0; i <= int'(wlen_q); i++) mem[waddr_q[10:3] + 8'(i)] <= wbuf[i];
        end
      end
      if (arvalid_i && arready_o) begin
        ar_got_q <= 1'b1;
        raddr_q  <= araddr_i;
        rlen_q   <= arlen_i;
        rcnt_q   <= '0;
      end
      if (ar_got_q && !rvalid_o && rnd_i[4]) begin
        rvalid_o <= 1'b1;
        rdata_o  <= raddr_q[31] ? '0 : mem[raddr_q[10:3] + rcnt_q];
        rresp_o  <= raddr_q[31] ? soc_pkg::RESP_SLVERR : soc_pkg::RESP_OKAY;
        rlast_o  <= (rcnt_q == rlen_q);
      end
      if (rvalid_o && rready_i) begin
        rvalid_o <= 1'b0;
        rcnt_q   <= rcnt_q + 8'd1;
        if (rlast_o) ar_got_q <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: test/tb_soc_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_soc_top;

  localparam int NROWS = 11;

  typedef struct packed {
    logic        op;
    logic [31:0] addr;
    logic [7:0]  blks;
    logic [7:0]  seed;  // mixed into the write data stream
    logic [1:0]  resp;
  } row_t;

  localparam row_t ROWS [NROWS] = '{
    '{soc_pkg::OP_WRITE, 32'h0000_0040, 8'd7, 8'h3c, soc_pkg::RESP_OKAY},
    '{soc_pkg::OP_READ,  32'h0000_0040, 8'd7, 8'h00, soc_pkg::RESP_OKAY},
    '{soc_pkg::OP_WRITE, 32'h0000_0100, 8'd7, 8'h5e, soc_pkg::RESP_OKAY},
    '{soc_pkg::OP_WRITE, 32'h0000_0100, 8'd1, 8'h91, soc_pkg::RESP_OKAY},  // short overwrite
    '{soc_pkg::OP_READ,  32'h0000_0100, 8'd7, 8'h00, soc_pkg::RESP_OKAY},
    '{soc_pkg::OP_READ,  32'h0000_0100, 8'd2, 8'h00, soc_pkg::RESP_OKAY},  // zeros above beat 2
    '{soc_pkg::OP_WRITE, 32'h8000_0200, 8'd3, 8'h27, soc_pkg::RESP_SLVERR},
    '{soc_pkg::OP_READ,  32'h8000_0200, 8'd7, 8'h00, soc_pkg::RESP_SLVERR},
    '{soc_pkg::OP_READ,  32'h0000_0200, 8'd7, 8'h00, soc_pkg::RESP_OKAY},
    '{soc_pkg::OP_WRITE, 32'h0000_0018, 8'd4, 8'hc8, soc_pkg::RESP_OKAY},
    '{soc_pkg::OP_READ,  32'h0000_0010, 8'd7, 8'h00, soc_pkg::RESP_OKAY}
  };

  logic                       clock;
  logic                       rst_n_i;
  logic                       user_valid_i;
  logic                       user_req_i;
  logic [soc_pkg::ADDR_W-1:0] user_addr_i;
  logic [7:0]                 user_blks_i;
  logic [soc_pkg::LINE_W-1:0] user_wdata_i;
  logic                       user_ready_o;
  logic [1:0]                 user_resp_o;
  logic [soc_pkg::LINE_W-1:0] user_rdata_o;
  logic                       io_master_awready_i;
  logic                       io_master_awvalid_o;
  logic [soc_pkg::ADDR_W-1:0] io_master_awaddr_o;
  logic [soc_pkg::ID_W-1:0]   io_master_awid_o;
  logic [7:0]                 io_master_awlen_o;
  logic [2:0]                 io_master_awsize_o;
  logic [1:0]                 io_master_awburst_o;
  logic                       io_master_wready_i;
  logic                       io_master_wvalid_o;
  logic [soc_pkg::DATA_W-1:0] io_master_wdata_o;
  logic [7:0]                 io_master_wstrb_o;
  logic                       io_master_wlast_o;
  logic                       io_master_bready_o;
  logic                       io_master_bvalid_i;
  logic [1:0]                 io_master_bresp_i;
  logic                       io_master_arready_i;
  logic                       io_master_arvalid_o;
  logic [soc_pkg::ADDR_W-1:0] io_master_araddr_o;
  logic [soc_pkg::ID_W-1:0]   io_master_arid_o;
  logic [7:0]                 io_master_arlen_o;
  logic [2:0]                 io_master_arsize_o;
  logic [1:0]                 io_master_arburst_o;
  logic                       io_master_rready_o;
  logic                       io_master_rvalid_i;
  logic [1:0]                 io_master_rresp_i;
  logic [soc_pkg::DATA_W-1:0] io_master_rdata_i;
  logic                       io_master_rlast_i;

  logic [soc_pkg::DATA_W-1:0] ref_mem [256];
  logic [soc_pkg::LINE_W-1:0] exp_line;
  logic [31:0]                data_seed;
  logic [31:0]                stall_seed;
  logic [4:0]                 stall_rnd;
  logic [7:0]                 cur_blks;
  logic [31:0]                cur_addr;
  int                         w_beat;
  int                         r_beat;

  soc_top dut (.*);

  axi_mem_model u_mem (
    .clock     (clock),
    .rst_n_i   (rst_n_i),
    .rnd_i     (stall_rnd),
    .awvalid_i (io_master_awvalid_o),
    .awready_o (io_master_awready_i),
    .awaddr_i  (io_master_awaddr_o),
    .awlen_i   (io_master_awlen_o),
    .wvalid_i  (io_master_wvalid_o),
    .wready_o  (io_master_wready_i),
    .wdata_i   (io_master_wdata_o),
    .wlast_i   (io_master_wlast_o),
    .bvalid_o  (io_master_bvalid_i),
    .bready_i  (io_master_bready_o),
    .bresp_o   (io_master_bresp_i),
    .arvalid_i (io_master_arvalid_o),
    .arready_o (io_master_arready_i),
    .araddr_i  (io_master_araddr_o),
    .arlen_i   (io_master_arlen_o),
    .rvalid_o  (io_master_rvalid_i),
    .rready_i  (io_master_rready_o),
    .rdata_o   (io_master_rdata_i),
    .rresp_o   (io_master_rresp_i),
    .rlast_o   (io_master_rlast_i)
  );

  function automatic logic [31:0] lcg(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic compare(input string name, input logic [511:0] got,
                         input logic [511:0] expected);
    if (got !== expected) begin
      $display("ERROR %s got=%0h exp=%0h", name, got, expected);
      $display("test failed");
      $fatal(1);
    end
  endtask

  task automatic run_row(input row_t row);
    int idx;
    cur_blks    = row.blks;
    cur_addr    = row.addr;
    user_req_i  = row.op;
    user_addr_i = row.addr;
    user_blks_i = row.blks;
    exp_line    = '0;
    if (row.op == soc_pkg::OP_WRITE) begin
      data_seed = data_seed ^ {24'd0, row.seed};
      for (int k = 0; k < 16; k++) begin
        data_seed = lcg(data_seed);
        user_wdata_i[k*32 +: 32] = data_seed;
      end
    end
    user_valid_i = 1'b1;
    do begin
      @(posedge clock);
      #2;
    end while (!user_ready_o);
    user_valid_i = 1'b0;
    compare("user_resp_o", user_resp_o, row.resp);
    for (int k = 0; k <= int'(row.blks); k++) begin
      idx = (int'(row.addr[10:3]) + k) % 256;
      if (row.addr[31]) continue;  // error region leaves memory alone and reads as zero
      if (row.op == soc_pkg::OP_WRITE) ref_mem[idx] = user_wdata_i[k*64 +: 64];
      else exp_line[k*64 +: 64] = ref_mem[idx];
    end
    if (row.op == soc_pkg::OP_READ) compare("user_rdata_o", user_rdata_o, exp_line);
  endtask

  initial clock = 1'b0;
  always #10 clock = ~clock;

  // new stall pattern each cycle
  always @(posedge clock) begin
    #2;
    stall_seed = lcg(stall_seed);
    stall_rnd  = stall_seed[20:16];
  end

  // beat checks at negedge where the handshake inputs are settled
  always @(negedge clock) begin
    if (io_master_awvalid_o) begin
      compare("io_master_awaddr_o", io_master_awaddr_o, cur_addr);
      compare("io_master_awlen_o", io_master_awlen_o, cur_blks);
      compare("io_master_awid_o", io_master_awid_o, 4'd0);
      compare("io_master_awsize_o", io_master_awsize_o, 3'd3);  // 8 bytes per beat
      compare("io_master_awburst_o", io_master_awburst_o, 2'd1);  // INCR
    end
    if (io_master_arvalid_o) begin
      compare("io_master_araddr_o", io_master_araddr_o, cur_addr);
      compare("io_master_arlen_o", io_master_arlen_o, cur_blks);
      compare("io_master_arid_o", io_master_arid_o, 4'd0);
      compare("io_master_arsize_o", io_master_arsize_o, 3'd3);
      compare("io_master_arburst_o", io_master_arburst_o, 2'd1);
    end
    if (io_master_wvalid_o && io_master_wready_i) begin
      compare("io_master_wdata_o", io_master_wdata_o, user_wdata_i[w_beat*64 +: 64]);
      compare("io_master_wstrb_o", io_master_wstrb_o, 8'hff);
      compare("io_master_wlast_o", io_master_wlast_o, w_beat == int'(cur_blks));
      w_beat = io_master_wlast_o ? 0 : w_beat + 1;
    end
    if (io_master_rvalid_i && io_master_rready_o) begin
      compare("io_master_rlast_i", io_master_rlast_i, r_beat == int'(cur_blks));
      r_beat = io_master_rlast_i ? 0 : r_beat + 1;
    end
  end

  initial begin
    repeat (NROWS * 200) @(posedge clock);
    $display("timeout: the DUT did not finish all requests in time");
    $display("test failed");
    $fatal(1);
  end

  initial begin
    rst_n_i      = 1'b0;
    user_valid_i = 1'b0;
    user_req_i   = 1'b0;
    user_addr_i  = '0;
    user_blks_i  = '0;
    user_wdata_i = '0;
    data_seed    = 32'd19;
    stall_seed   = 32'd19;
    stall_rnd    = '0;
    cur_blks     = '0;
    cur_addr     = '0;
    w_beat       = 0;
    r_beat       = 0;
    for (int i = 0; i < 256; i++) ref_mem[i] = {32'h1000_0000 + 32'(i), 32'hffff_ffff - 32'(i)};
    repeat (5) @(posedge clock);
    #2;
    rst_n_i = 1'b1;
    compare("io_master_awvalid_o", io_master_awvalid_o, 1'b0);
    compare("io_master_wvalid_o", io_master_wvalid_o, 1'b0);
    compare("io_master_bready_o", io_master_bready_o, 1'b0);
    compare("io_master_arvalid_o", io_master_arvalid_o, 1'b0);
    compare("io_master_rready_o", io_master_rready_o, 1'b0);
    compare("user_ready_o", user_ready_o, 1'b0);
    for (int n = 0; n < NROWS; n++) run_row(ROWS[n]);
    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: soc_top.f
design/soc_pkg.sv
design/axi_rw_ctrl.sv
design/wdata_serializer.sv
design/rdata_assembler.sv
design/soc_top.sv
test/axi_mem_model.sv
test/tb_soc_top.sv

// File: run.sh
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_soc_top -f soc_top.f -o sim_tb_soc_top

# the pipeline fails when grep finds no pass line
./obj_dir/sim_tb_soc_top | tee /dev/stderr | grep "^test passed$" > /dev/null
echo "simulation run finished without errors"
